// ==== logic/uart_boot_consts.svh ====
`ifndef UART_BOOT_CONSTS_SVH
`define UART_BOOT_CONSTS_SVH

// ----------------------------------------------------------
// Serial timing
// ----------------------------------------------------------
`define UART_CYCLES_PER_BIT 16        // Clocks per serial bit, short for simulation
`define UART_COUNT_W        5         // Bit timing counter, holds one full bit

// ----------------------------------------------------------
// Data and memory geometry
// ----------------------------------------------------------
`define BYTE_W              8
`define WORD_W              32
`define BYTES_PER_WORD      4         // Little-endian, first byte lands in [7:0]
`define IMEM_ADDR_W         8
`define IMEM_DEPTH          256

// All-ones word closes the load phase
`define LOAD_END_WORD       32'hFFFF_FFFF

`endif

// ==== logic/uart_boot_pkg.sv ====
`include "uart_boot_consts.svh"

package uart_boot_pkg;

    // ----------------------------------------------------------
    // Payload widths
    // ----------------------------------------------------------
    typedef logic [`BYTE_W-1:0]      byte_t;       // One serial byte
    typedef logic [`WORD_W-1:0]      word_t;       // One instruction
    typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;  // Word address into imem

    // Byte lane within a word being assembled
    typedef logic [$clog2(`BYTES_PER_WORD)-1:0] byte_idx_t;

    // ----------------------------------------------------------
    // Receiver FSM
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // Line high, waiting for start edge
        START = 2'd1,  // Checking start bit at its middle
        RECV  = 2'd2,  // Shifting in data bits
        STOP  = 2'd3   // Waiting for middle of stop bit
    } rx_state_e;

endpackage

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_boot_consts.svh"

module uart_rx (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 rxd,       // Serial line, idle high
    input  logic                 rx_en,     // Freezes the synchronizer when low
    output logic                 rx_valid,  // One cycle, mid stop bit
    output logic                 rx_break,  // Zero byte received
    output uart_boot_pkg::byte_t rx_data
);
    import uart_boot_pkg::*;

    localparam int cnt_w = `UART_COUNT_W;
    localparam int bit_w = $clog2(`BYTE_W);

    // Counter values that mark the middle of a bit
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(`UART_CYCLES_PER_BIT / 2 - 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`UART_CYCLES_PER_BIT - 1);
    localparam logic [bit_w-1:0] last_idx = bit_w'(`BYTE_W - 1);

    logic [1:0]       sync_q;     // Two-flop synchronizer
    logic             rxd_s;      // Synchronized line
    rx_state_e        state_q;
    rx_state_e        state_d;
    logic [cnt_w-1:0] cycle_q;    // Clocks within current bit
    logic [bit_w-1:0] bit_q;      // Data bit index
    byte_t            shift_q;    // Bits arrive LSB first
    logic             mid_start;
    logic             bit_tick;

    // ----------------------------------------------------------
    // Input synchronizer
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sync_q <= 2'b11;                     // Line looks idle
        end else if (rx_en) begin
            sync_q <= {sync_q[0], rxd};
        end
    end

    assign rxd_s = sync_q[1];

    // Mid-start check, then one tick per bit at its centre
    assign mid_start = (state_q == START) && (cycle_q == half_cnt);
    assign bit_tick  = ((state_q == RECV) || (state_q == STOP)) && (cycle_q == full_cnt);

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!rxd_s) begin
                    state_d = START;             // Falling edge seen
                end
            end
            START: begin
                if (mid_start) begin
                    state_d = rxd_s ? IDLE : RECV;  // High again means a glitch
                end
            end
            RECV: begin
                if (bit_tick && (bit_q == last_idx)) begin
                    state_d = STOP;
                end
            end
            STOP: begin
                if (bit_tick) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // ----------------------------------------------------------
    // State, bit timing and bit index
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= IDLE;
            cycle_q <= '0;
            bit_q   <= '0;
        end else begin
            state_q <= state_d;
            // Restart count at every bit boundary
            if ((state_q == IDLE) || mid_start || bit_tick) begin
                cycle_q <= '0;
            end else begin
                cycle_q <= cycle_q + 1'b1;
            end
            if (state_q != RECV) begin
                bit_q <= '0;
            end else if (bit_tick) begin
                bit_q <= bit_q + 1'b1;
            end
        end
    end

    // Shift register, new bit in at the top
    always_ff @(posedge clk) begin
        if ((state_q == RECV) && bit_tick) begin
            shift_q <= {rxd_s, shift_q[`BYTE_W-1:1]};
        end
    end

    // Byte is complete for the whole stop bit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rx_data <= '0;
        end else if (state_q == STOP) begin
            rx_data <= shift_q;
        end
    end

    assign rx_valid = (state_q == STOP) && bit_tick;
    assign rx_break = rx_valid && (shift_q == '0);  // Same cycle as the valid pulse

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    // Every byte yields a single strobe
    a_valid_single: assert property (
        @(posedge clk) disable iff (!resetn) rx_valid |=> !rx_valid
    );

endmodule

// ==== logic/boot_loader.sv ====
`timescale 1ns/1ps
`include "uart_boot_consts.svh"

module boot_loader (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      rx_valid,
    input  uart_boot_pkg::byte_t      rx_data,
    input  logic                      fetch_en,
    input  uart_boot_pkg::imem_addr_t fetch_addr,
    output logic                      load_done,
    output uart_boot_pkg::imem_addr_t word_count,
    output logic                      fetch_valid,
    output logic                      mem_en,
    output logic                      mem_we,
    output uart_boot_pkg::imem_addr_t mem_addr,
    output uart_boot_pkg::word_t      mem_wdata
);
    import uart_boot_pkg::*;

    // Lower three bytes of the word in progress
    logic [`WORD_W-`BYTE_W-1:0] part_q;
    byte_idx_t                  byte_idx_q;  // Lane of the next byte
    word_t                      assembled;   // Full word on the last byte
    logic                       take_byte;
    logic                       last_byte;
    logic                       is_end;
    logic                       wr_word;

    // ----------------------------------------------------------
    // Word assembly
    // ----------------------------------------------------------
    assign take_byte = rx_valid && !load_done;   // Bytes after the end are dropped
    assign last_byte = take_byte && (byte_idx_q == byte_idx_t'(`BYTES_PER_WORD - 1));
    assign assembled = {rx_data, part_q};        // Fourth byte goes on top
    assign is_end    = (assembled == `LOAD_END_WORD);
    assign wr_word   = last_byte && !is_end;     // Terminator is never stored

    // Shift from the top, first byte ends up in [7:0]
    always_ff @(posedge clk) begin
        if (take_byte && !last_byte) begin
            part_q <= {rx_data, part_q[`WORD_W-`BYTE_W-1:`BYTE_W]};
        end
    end

    // ----------------------------------------------------------
    // Load progress and fetch strobe
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            byte_idx_q  <= '0;
            word_count  <= '0;
            load_done   <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            if (take_byte) begin
                byte_idx_q <= byte_idx_q + 1'b1;  // Wraps to lane 0 after the fourth
            end
            if (wr_word) begin
                word_count <= word_count + 1'b1;  // Wraps at depth
            end
            if (last_byte && is_end) begin
                load_done <= 1'b1;                // Sticky until reset
            end
            // Read data shows up one edge after the request
            fetch_valid <= load_done && fetch_en;
        end
    end

    // ----------------------------------------------------------
    // Memory port, loader writes first, fetches once loaded
    // ----------------------------------------------------------
    assign mem_en    = load_done ? fetch_en : wr_word;
    assign mem_we    = wr_word;
    assign mem_addr  = load_done ? fetch_addr : word_count;
    assign mem_wdata = assembled;

    // No writes may reach imem once fetching has started
    a_no_write_after_done: assert property (
        @(posedge clk) disable iff (!resetn) load_done |-> !mem_we
    );

    // Write strobe only with the port enabled
    a_we_needs_en: assert property (
        @(posedge clk) disable iff (!resetn) mem_we |-> mem_en
    );

endmodule

// ==== logic/imem_sram.sv ====
`timescale 1ns/1ps
`include "uart_boot_consts.svh"

module imem_sram (
    input  logic                      clk,
    input  logic                      en,     // Port enable
    input  logic                      we,     // Write when set, else read
    input  uart_boot_pkg::imem_addr_t addr,
    input  uart_boot_pkg::word_t      wdata,
    output uart_boot_pkg::word_t      rdata   // Registered, holds between reads
);
    import uart_boot_pkg::*;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    word_t mem [`IMEM_DEPTH];

    // Single port, one access per enabled edge
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    // Address from the loader mux must be clean on every access
    a_addr_known: assert property (
        @(posedge clk) en |-> !$isunknown(addr)
    );

endmodule

// ==== logic/uart_boot_top.sv ====
`timescale 1ns/1ps
`include "uart_boot_consts.svh"

module uart_boot_top (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      rxd,          // Serial line in
    input  logic                      rx_en,
    input  logic                      fetch_en,
    input  uart_boot_pkg::imem_addr_t fetch_addr,
    output logic                      rx_valid,
    output logic                      rx_break,
    output uart_boot_pkg::byte_t      rx_data,
    output logic                      load_done,
    output uart_boot_pkg::imem_addr_t word_count,   // Words stored so far
    output logic                      fetch_valid,
    output uart_boot_pkg::word_t      fetch_data
);
    import uart_boot_pkg::*;

    // ----------------------------------------------------------
    // Memory port between loader and imem
    // ----------------------------------------------------------
    logic       mem_en;
    logic       mem_we;
    imem_addr_t mem_addr;
    word_t      mem_wdata;
    word_t      mem_rdata;

    uart_rx u_rx (
        .clk      (clk),
        .resetn   (resetn),
        .rxd      (rxd),
        .rx_en    (rx_en),
        .rx_valid (rx_valid),
        .rx_break (rx_break),
        .rx_data  (rx_data)
    );

    boot_loader u_loader (
        .clk         (clk),
        .resetn      (resetn),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .load_done   (load_done),
        .word_count  (word_count),
        .fetch_valid (fetch_valid),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    imem_sram u_imem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    assign fetch_data = mem_rdata;  // Lines up with fetch_valid

endmodule

// ==== sim/tb_uart_boot.sv ====
`timescale 1ns/1ps
`include "uart_boot_consts.svh"

module tb_uart_boot;
    import uart_boot_pkg::*;

    localparam int cpb          = `UART_CYCLES_PER_BIT;
    localparam int frame_cycles = 10 * cpb;    // Start, 8 data, stop
    localparam int pipe_len     = 32;          // Back-to-back fetch burst

    logic       clk;
    logic       resetn;
    logic       rxd;
    logic       rx_en;
    logic       fetch_en;
    imem_addr_t fetch_addr;
    logic       rx_valid;
    logic       rx_break;
    byte_t      rx_data;
    logic       load_done;
    imem_addr_t word_count;
    logic       fetch_valid;
    word_t      fetch_data;

    logic [31:0] lcg_state;
    byte_t       expect_q [$];           // Bytes on the wire, not yet strobed
    word_t       model_mem [imem_addr_t];  // Expected imem contents
    int          exp_count;
    logic        loaded;                 // Terminator taken, fetches now served
    logic        fetch_pending;          // Request taken at the coming edge
    imem_addr_t  pend_addr;
    byte_t       exp_byte;

    uart_boot_top dut0 (
        .clk         (clk),
        .resetn      (resetn),
        .rxd         (rxd),
        .rx_en       (rx_en),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .rx_valid    (rx_valid),
        .rx_break    (rx_break),
        .rx_data     (rx_data),
        .load_done   (load_done),
        .word_count  (word_count),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;              // 20 ns period
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_rx_drain(input int max_cycles);
        int n;
        n = 0;
        while (expect_q.size() != 0) begin
            if (n >= max_cycles) begin
                abort_run("Timed out waiting for rx_valid on a byte that was sent");
            end else begin
                tick();
                n++;
            end
        end
    endtask

    task automatic wait_load_done(input int max_cycles);
        int n;
        n = 0;
        while (load_done !== 1'b1) begin
            if (n >= max_cycles) begin
                abort_run("Timed out waiting for load_done after the terminator word");
            end else begin
                tick();
                n++;
            end
        end
    endtask

    // ----------------------------------------------------------
    // UART driver
    // ----------------------------------------------------------
    // Per frame the rx FSM walks IDLE, START, RECV, STOP
    task automatic send_byte(input byte_t b, input bit expect_rx);
        int i;
        if (expect_rx) begin
            expect_q.push_back(b);
        end
        rxd = 1'b0;                          // Start bit
        repeat (cpb) tick();
        for (i = 0; i < `BYTE_W; i++) begin
            rxd = b[i];                      // LSB first
            repeat (cpb) tick();
        end
        rxd = 1'b1;                          // Stop bit, line back to idle
        repeat (cpb) tick();
        if (expect_rx) begin
            wait_rx_drain(cpb);
        end
    endtask

    // Little-endian, lane 0 goes out first
    task automatic send_word(input word_t w);
        int lane;
        for (lane = 0; lane < `BYTES_PER_WORD; lane++) begin
            send_byte(w[lane*`BYTE_W +: `BYTE_W], 1'b1);
        end
    endtask

    // ----------------------------------------------------------
    // Monitors, sampled mid-cycle
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (resetn && rx_valid) begin
            if (expect_q.size() == 0) begin
                abort_run($sformatf("rx_valid at %0d ns without a byte on the line", $time));
            end else begin
                exp_byte = expect_q.pop_front();
                compare_value("rx_data", 32'(rx_data), 32'(exp_byte));
                compare_value("rx_break", 32'(rx_break), (exp_byte == 8'h00) ? 32'd1 : 32'd0);
            end
        end else if (resetn) begin
            compare_value("rx_break without rx_valid", 32'(rx_break), 32'd0);
        end
    end

    // Result one cycle after each accepted fetch, in issue order
    always @(negedge clk) begin
        if (!resetn) begin
            fetch_pending = 1'b0;
        end else begin
            compare_value("fetch_valid", 32'(fetch_valid), 32'(fetch_pending));
            if (fetch_pending) begin
                if (!model_mem.exists(pend_addr)) begin
                    abort_run($sformatf("Fetch of address %0d that was never loaded",
                                        pend_addr));
                end else begin
                    compare_value($sformatf("fetch_data at address %0d", pend_addr),
                                  fetch_data, model_mem[pend_addr]);
                end
            end
            fetch_pending = fetch_en && loaded;  // Ignored before loading ends
            pend_addr     = fetch_addr;
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        int    n_words;
        int    i;
        int    lane;
        word_t w;

        rxd            = 1'b1;
        rx_en          = 1'b1;
        fetch_en       = 1'b0;
        fetch_addr     = '0;
        resetn         = 1'b0;
        lcg_state      = 32'haebec2e7;
        exp_count      = 0;
        loaded         = 1'b0;

        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b1;

        // Reset values, then fetches that must be ignored
        compare_value("rx_valid after reset", 32'(rx_valid), 32'd0);
        compare_value("rx_break after reset", 32'(rx_break), 32'd0);
        compare_value("rx_data after reset", 32'(rx_data), 32'd0);
        compare_value("load_done after reset", 32'(load_done), 32'd0);
        compare_value("word_count after reset", 32'(word_count), 32'd0);
        compare_value("fetch_valid after reset", 32'(fetch_valid), 32'd0);
        compare_value("mem_en after reset", 32'(dut0.mem_en), 32'd0);
        compare_value("mem_we after reset", 32'(dut0.mem_we), 32'd0);
        for (i = 0; i < 4; i++) begin
            fetch_en   = 1'b1;
            fetch_addr = imem_addr_t'(next_random());
            tick();
            fetch_en   = 1'b0;
            tick();
        end
        tick();

        // Frame with the receiver disabled
        rx_en = 1'b0;
        tick();
        send_byte(byte_t'(next_random()), 1'b0);
        repeat (2 * frame_cycles) tick();
        compare_value("word_count with rx_en low", 32'(word_count), 32'd0);
        rx_en = 1'b1;
        repeat (cpb) tick();                 // Idle line before next frame

        // Load random words, some with a zero lane
        n_words = 5 + int'(next_random() % 32'd16);
        for (i = 0; i < n_words; i++) begin
            w = next_random();
            while (w == `LOAD_END_WORD) begin
                w = next_random();
            end
            if ((i % 3) == 0) begin
                lane = i % `BYTES_PER_WORD;
                w[lane*`BYTE_W +: `BYTE_W] = '0;
            end
            model_mem[imem_addr_t'(i)] = w;
            exp_count++;
            send_word(w);
            compare_value("word_count while loading", 32'(word_count), 32'(exp_count));
            compare_value("load_done while loading", 32'(load_done), 32'd0);
        end

        // Terminator closes the load
        send_word(`LOAD_END_WORD);
        wait_load_done(frame_cycles);
        loaded = 1'b1;
        compare_value("word_count after terminator", 32'(word_count), 32'(exp_count));

        // Late bytes still strobe but are not stored
        for (i = 0; i < `BYTES_PER_WORD; i++) begin
            send_byte(byte_t'(next_random()), 1'b1);
        end
        compare_value("word_count after late bytes", 32'(word_count), 32'(exp_count));
        compare_value("load_done after late bytes", 32'(load_done), 32'd1);

        // Single fetches with idle gaps
        for (i = 0; i < n_words; i++) begin
            fetch_en   = 1'b1;
            fetch_addr = imem_addr_t'(i);
            tick();
            fetch_en   = 1'b0;
            tick();
            tick();
        end

        // Burst, one request every cycle
        for (i = 0; i < pipe_len; i++) begin
            fetch_en   = 1'b1;
            fetch_addr = imem_addr_t'(next_random() % 32'(n_words));
            tick();
        end
        fetch_en = 1'b0;
        tick();
        tick();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== uart_boot.f ====
+incdir+logic
logic/uart_boot_pkg.sv
logic/uart_rx.sv
logic/boot_loader.sv
logic/imem_sram.sv
logic/uart_boot_top.sv
sim/tb_uart_boot.sv

// ==== Makefile ====
# Verilator build and run for the UART boot loader

VERILATOR ?= verilator
TOP       ?= tb_uart_boot
FILELIST  ?= uart_boot.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= Test completed successfully

SIM_BIN := $(BUILD_DIR)/$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# Fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
